/* source/sv32_mmu_params.svh */
`ifndef SV32_MMU_PARAMS_SVH
`define SV32_MMU_PARAMS_SVH

// ====================
// Sv32 page geometry
// ====================
`define SV32_PAGE_SHIFT 12  // 4 KiB base page
`define SV32_VPN_BITS   10  // One VPN field, two levels
`define SV32_PPN_BITS   22  // PPN[1] 12 bits, PPN[0] 10 bits
`define SV32_PA_BITS    34  // Full Sv32 physical address

// Bytes per page-table entry
`define SV32_PTE_BYTES  4

// ====================
// TLB sizing
// ====================
`define MMU_TLB_ENTRIES 8   // Power of 2 only

`endif

/* source/sv32_mmu_pkg.sv */
`default_nettype none

`include "sv32_mmu_params.svh"

package sv32_mmu_pkg;

  // PTE flag byte, D down to V
  typedef struct packed {
    logic d;  // Dirty
    logic a;  // Accessed
    logic g;  // Global
    logic u;  // User page
    logic x;
    logic w;
    logic r;
    logic v;  // Valid
  } pte_flags_t;

  typedef logic [2*`SV32_VPN_BITS-1:0] vpn_t;  // VPN[1], VPN[0]
  typedef logic [`SV32_PPN_BITS-1:0]   ppn_t;
  typedef logic [`SV32_PA_BITS-1:0]    paddr_t;

  // 32-bit Sv32 PTE as read from memory
  typedef struct packed {
    ppn_t       ppn;
    logic [1:0] rsw;  // Software bits, ignored by hardware
    pte_flags_t flags;
  } pte_t;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_t;

  typedef struct packed {
    logic       valid;
    vpn_t       vpn;
    ppn_t       ppn;
    pte_flags_t flags;
    logic       megapage;  // Level-1 leaf, 4 MiB
  } tlb_entry_t;

  // Leaf PA, megapage keeps VA[21:0] and only PPN[1]
  function automatic paddr_t leaf_paddr(ppn_t ppn, logic [31:0] vaddr, logic megapage);
    if (megapage) begin
      return {ppn[`SV32_PPN_BITS-1:`SV32_VPN_BITS],
              vaddr[`SV32_VPN_BITS+`SV32_PAGE_SHIFT-1:0]};
    end
    return {ppn, vaddr[`SV32_PAGE_SHIFT-1:0]};  // 4 KiB page
  endfunction

endpackage

`default_nettype wire

/* source/mmu_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// Combinational TLB probe, answered in the same cycle
interface tlb_lookup_if;
  sv32_mmu_pkg::vpn_t       vpn;
  logic                     hit;
  sv32_mmu_pkg::ppn_t       ppn;
  sv32_mmu_pkg::pte_flags_t flags;
  logic                     megapage;

  modport requester (output vpn, input hit, ppn, flags, megapage);
  modport responder (input vpn, output hit, ppn, flags, megapage);
endinterface

// One-cycle fill pulse from the walker
interface tlb_fill_if;
  logic                     fill;
  sv32_mmu_pkg::vpn_t       vpn;
  sv32_mmu_pkg::ppn_t       ppn;
  sv32_mmu_pkg::pte_flags_t flags;
  logic                     megapage;

  modport source (output fill, vpn, ppn, flags, megapage);
  modport sink   (input fill, vpn, ppn, flags, megapage);
endinterface

// Walk launch and completion
interface page_walk_if;
  logic                 start;     // Pulse
  logic [31:0]          vaddr;
  sv32_mmu_pkg::ppn_t   root_ppn;  // From satp
  logic                 done;      // Pulse, fault/paddr valid here
  logic                 fault;
  sv32_mmu_pkg::paddr_t paddr;

  modport launcher (output start, vaddr, root_ppn, input done, fault, paddr);
  modport walker   (input start, vaddr, root_ppn, output done, fault, paddr);
endinterface

`default_nettype wire

/* source/mmu_tlb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sv32_mmu_params.svh"

module mmu_tlb #(
  parameter int TLB_ENTRIES = `MMU_TLB_ENTRIES
) (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            flush_all,
  input  logic            flush_page,
  input  logic [31:0]     flush_vaddr,
  tlb_lookup_if.responder lk,
  tlb_fill_if.sink        fl
);

  localparam int IDX_BITS = $clog2(TLB_ENTRIES);
  localparam int VB       = `SV32_VPN_BITS;

  sv32_mmu_pkg::tlb_entry_t entries [TLB_ENTRIES];
  logic [IDX_BITS-1:0]      rr_idx;     // Next victim
  sv32_mmu_pkg::vpn_t       flush_vpn;

  // Megapage entries compare VPN[1] only
  function automatic logic entry_match(sv32_mmu_pkg::tlb_entry_t e,
                                       sv32_mmu_pkg::vpn_t vpn);
    logic hi_eq;
    logic lo_eq;
    hi_eq = (e.vpn[2*VB-1:VB] == vpn[2*VB-1:VB]);
    lo_eq = (e.vpn[VB-1:0] == vpn[VB-1:0]);
    return e.valid && hi_eq && (e.megapage || lo_eq);
  endfunction

  assign flush_vpn = flush_vaddr[31:`SV32_PAGE_SHIFT];

  // ====================
  // Lookup
  // ====================
  always_comb begin
    lk.hit      = 1'b0;
    lk.ppn      = '0;
    lk.flags    = '0;
    lk.megapage = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (entry_match(entries[i], lk.vpn)) begin  // At most one match expected
        lk.hit      = 1'b1;
        lk.ppn      = entries[i].ppn;
        lk.flags    = entries[i].flags;
        lk.megapage = entries[i].megapage;
      end
    end
  end

  // ====================
  // Fill and flush
  // ====================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rr_idx <= '0;
      for (int i = 0; i < TLB_ENTRIES; i++) begin
        entries[i] <= '0;
      end
    end else if (flush_all) begin
      for (int i = 0; i < TLB_ENTRIES; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else if (flush_page) begin
      // Same match rule as lookup, so a megapage goes too
      for (int i = 0; i < TLB_ENTRIES; i++) begin
        if (entry_match(entries[i], flush_vpn)) begin
          entries[i].valid <= 1'b0;
        end
      end
    end else if (fl.fill) begin  // Fill loses to any flush
      entries[rr_idx] <= '{valid:    1'b1,
                           vpn:      fl.vpn,
                           ppn:      fl.ppn,
                           flags:    fl.flags,
                           megapage: fl.megapage};
      rr_idx <= rr_idx + 1'b1;  // Round robin, wraps
    end
  end

endmodule

`default_nettype wire

/* source/mmu_perm_check.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_perm_check (
  input  sv32_mmu_pkg::pte_flags_t flags,
  input  logic                     is_store,
  input  logic                     is_fetch,
  input  sv32_mmu_pkg::priv_t      priv,
  input  logic                     sum,
  input  logic                     mxr,
  output logic                     allowed
);

  logic leaf_ok;
  logic priv_ok;
  logic access_ok;

  // Valid, some permission bit, and no W without R
  assign leaf_ok = flags.v && (flags.r || flags.w || flags.x) && !(flags.w && !flags.r);

  // Privilege against the U bit
  always_comb begin
    case (priv)
      sv32_mmu_pkg::PRIV_U: priv_ok = flags.u;
      sv32_mmu_pkg::PRIV_S: priv_ok = !flags.u || sum;  // SUM opens U pages
      default:              priv_ok = 1'b1;
    endcase
  end

  // Access type
  always_comb begin
    if (is_fetch) begin
      access_ok = flags.x;
    end else if (is_store) begin
      access_ok = flags.w;
    end else begin
      access_ok = flags.r || (flags.x && mxr);  // MXR lets loads read X pages
    end
  end

  assign allowed = leaf_ok && priv_ok && access_ok;

endmodule

`default_nettype wire

/* source/mmu_page_walker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sv32_mmu_params.svh"

module mmu_page_walker (
  input  logic                 clk,
  input  logic                 reset_n,
  output logic                 mem_req,
  output sv32_mmu_pkg::paddr_t mem_addr,
  input  logic                 mem_ack,
  input  logic [31:0]          mem_rdata,
  input  logic                 is_store,
  input  logic                 is_fetch,
  input  sv32_mmu_pkg::priv_t  priv,
  input  logic                 sum,
  input  logic                 mxr,
  page_walk_if.walker          pw,
  tlb_fill_if.source           tf
);

  localparam int VB = `SV32_VPN_BITS;
  localparam int PS = `SV32_PAGE_SHIFT;

  typedef enum logic [1:0] {W_IDLE, W_READ, W_RELEASE} walk_state_t;

  walk_state_t        state;
  logic               level;     // 1 at root table
  logic               descend;   // Second read pending
  logic [31:0]        vaddr_q;
  sv32_mmu_pkg::pte_t pte;
  logic               pte_leaf;
  logic               pte_allowed;
  logic               walk_ok;
  logic               walk_down;

  // PTE address = ppn * page + index * PTE size
  function automatic sv32_mmu_pkg::paddr_t pte_addr(sv32_mmu_pkg::ppn_t ppn,
                                                    logic [VB-1:0] idx);
    return {ppn, PS'(0)} + sv32_mmu_pkg::paddr_t'(idx) * `SV32_PTE_BYTES;
  endfunction

  // ====================
  // PTE decode
  // ====================
  assign pte       = sv32_mmu_pkg::pte_t'(mem_rdata);
  assign pte_leaf  = pte.flags.r || pte.flags.x;
  assign walk_ok   = pte.flags.v && pte_leaf && pte_allowed;
  assign walk_down = pte.flags.v && !pte_leaf && level;  // Pointer at level 0 faults

  mmu_perm_check u_leaf_perm (
    .flags    (pte.flags),
    .is_store (is_store),
    .is_fetch (is_fetch),
    .priv     (priv),
    .sum      (sum),
    .mxr      (mxr),
    .allowed  (pte_allowed)
  );

  // ====================
  // Walk FSM
  // ====================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state    <= W_IDLE;
      level    <= 1'b0;
      descend  <= 1'b0;
      mem_req  <= 1'b0;
      pw.done  <= 1'b0;
      pw.fault <= 1'b0;
      tf.fill  <= 1'b0;
    end else begin
      pw.done <= 1'b0;  // Single-cycle pulses
      tf.fill <= 1'b0;
      case (state)
        W_IDLE: begin
          if (pw.start) begin
            mem_req <= 1'b1;  // Root PTE read
            level   <= 1'b1;
            state   <= W_READ;
          end
        end
        W_READ: begin
          if (mem_ack) begin
            mem_req  <= 1'b0;
            level    <= 1'b0;
            descend  <= walk_down;
            pw.done  <= !walk_down;
            pw.fault <= !walk_ok && !walk_down;
            tf.fill  <= walk_ok;   // Lands with done
            state    <= W_RELEASE;
          end
        end
        W_RELEASE: begin
          if (!mem_ack) begin  // Four-phase return to zero
            if (descend) begin
              mem_req <= 1'b1;
              descend <= 1'b0;
              state   <= W_READ;
            end else begin
              state <= W_IDLE;
            end
          end
        end
        default: state <= W_IDLE;
      endcase
    end
  end

  // Address and result payload
  always_ff @(posedge clk) begin
    if (state == W_IDLE && pw.start) begin
      vaddr_q  <= pw.vaddr;
      mem_addr <= pte_addr(pw.root_ppn, pw.vaddr[31:PS+VB]);  // VPN[1]
    end
    if (state == W_READ && mem_ack) begin
      mem_addr    <= pte_addr(pte.ppn, vaddr_q[PS+VB-1:PS]);  // VPN[0], used on descend
      pw.paddr    <= sv32_mmu_pkg::leaf_paddr(pte.ppn, vaddr_q, level);
      tf.vpn      <= vaddr_q[31:PS];
      tf.ppn      <= pte.ppn;
      tf.flags    <= pte.flags;
      tf.megapage <= level;  // Leaf found at root
    end
  end

endmodule

`default_nettype wire

/* source/mmu_xlate_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sv32_mmu_params.svh"

module mmu_xlate_ctrl (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 req,
  input  logic [31:0]          vaddr,
  input  logic                 is_store,
  input  logic                 is_fetch,
  input  logic [31:0]          satp,
  input  sv32_mmu_pkg::priv_t  priv,
  input  logic                 sum,
  input  logic                 mxr,
  output logic                 ack,
  output sv32_mmu_pkg::paddr_t paddr,
  output logic                 page_fault,
  tlb_lookup_if.requester      lk,
  page_walk_if.launcher        pw
);

  typedef enum logic [1:0] {C_IDLE, C_WAIT_WALK, C_ACK, C_DRAIN} ctrl_state_t;

  ctrl_state_t          state;
  logic                 xlate_on;
  logic                 hit_allowed;
  sv32_mmu_pkg::paddr_t direct_pa;    // Bare or hit result
  logic                 direct_fault;

  // satp MODE is bit 31, M-mode never translates
  assign xlate_on    = satp[31] && (priv != sv32_mmu_pkg::PRIV_M);
  assign pw.root_ppn = satp[`SV32_PPN_BITS-1:0];
  assign pw.vaddr    = vaddr;  // Held stable by requester
  assign lk.vpn      = vaddr[31:`SV32_PAGE_SHIFT];

  mmu_perm_check u_hit_perm (
    .flags    (lk.flags),
    .is_store (is_store),
    .is_fetch (is_fetch),
    .priv     (priv),
    .sum      (sum),
    .mxr      (mxr),
    .allowed  (hit_allowed)
  );

  assign direct_pa = xlate_on ? sv32_mmu_pkg::leaf_paddr(lk.ppn, vaddr, lk.megapage)
                              : sv32_mmu_pkg::paddr_t'(vaddr);
  assign direct_fault = xlate_on && !hit_allowed;

  // ====================
  // Request FSM
  // ====================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= C_IDLE;
      ack        <= 1'b0;
      page_fault <= 1'b0;
      pw.start   <= 1'b0;
    end else begin
      pw.start <= 1'b0;
      case (state)
        C_IDLE: begin
          if (req) begin
            if (xlate_on && !lk.hit) begin
              pw.start <= 1'b1;  // Miss
              state    <= C_WAIT_WALK;
            end else begin
              page_fault <= direct_fault;
              state      <= C_ACK;
            end
          end
        end
        C_WAIT_WALK: begin
          if (pw.done) begin
            page_fault <= pw.fault;
            state      <= C_ACK;
          end
        end
        C_ACK: begin
          ack   <= 1'b1;
          state <= C_DRAIN;
        end
        C_DRAIN: begin
          if (!req) begin  // Hold until requester lets go
            ack        <= 1'b0;
            page_fault <= 1'b0;
            state      <= C_IDLE;
          end
        end
        default: state <= C_IDLE;
      endcase
    end
  end

  // Result register
  always_ff @(posedge clk) begin
    if (state == C_IDLE && req) begin
      paddr <= direct_pa;
    end
    if (state == C_WAIT_WALK && pw.done) begin
      paddr <= pw.paddr;
    end
  end

endmodule

`default_nettype wire

/* source/sv32_mmu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sv32_mmu_params.svh"

module sv32_mmu (
  input  logic                     clk,
  input  logic                     reset_n,
  // Translation request
  input  logic                     req,
  input  logic [31:0]              vaddr,
  input  logic                     is_store,
  input  logic                     is_fetch,
  output logic                     ack,
  output logic [`SV32_PA_BITS-1:0] paddr,
  output logic                     page_fault,
  // Page-table memory, MMU is master
  output logic                     mem_req,
  output logic [`SV32_PA_BITS-1:0] mem_addr,
  input  logic                     mem_ack,
  input  logic [31:0]              mem_rdata,
  // CSR state
  input  logic [31:0]              satp,
  input  logic [1:0]               priv,
  input  logic                     mstatus_sum,
  input  logic                     mstatus_mxr,
  // TLB maintenance
  input  logic                     flush_all,
  input  logic                     flush_page,
  input  logic [31:0]              flush_vaddr
);

  tlb_lookup_if lk_if ();
  tlb_fill_if   fill_if ();
  page_walk_if  walk_if ();

  // ====================
  // Blocks
  // ====================
  mmu_xlate_ctrl u_ctrl (
    .clk        (clk),
    .reset_n    (reset_n),
    .req        (req),
    .vaddr      (vaddr),
    .is_store   (is_store),
    .is_fetch   (is_fetch),
    .satp       (satp),                          // Decoded inside
    .priv       (sv32_mmu_pkg::priv_t'(priv)),
    .sum        (mstatus_sum),
    .mxr        (mstatus_mxr),
    .ack        (ack),
    .paddr      (paddr),
    .page_fault (page_fault),
    .lk         (lk_if.requester),
    .pw         (walk_if.launcher)
  );

  mmu_tlb #(
    .TLB_ENTRIES (`MMU_TLB_ENTRIES)
  ) u_tlb (
    .clk         (clk),
    .reset_n     (reset_n),
    .flush_all   (flush_all),
    .flush_page  (flush_page),
    .flush_vaddr (flush_vaddr),
    .lk          (lk_if.responder),
    .fl          (fill_if.sink)
  );

  mmu_page_walker u_walker (
    .clk       (clk),
    .reset_n   (reset_n),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .is_store  (is_store),
    .is_fetch  (is_fetch),
    .priv      (sv32_mmu_pkg::priv_t'(priv)),
    .sum       (mstatus_sum),
    .mxr       (mstatus_mxr),
    .pw        (walk_if.walker),
    .tf        (fill_if.source)
  );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 4,  // 8 ns clock
  parameter int RESET_CYCLES   = 5
) (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // Release just after an edge
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/tb_sv32_mmu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sv32_mmu_params.svh"

module tb_sv32_mmu;

  localparam int NUM_TESTS    = 6;
  localparam int RR_PAGES     = `MMU_TLB_ENTRIES + 1;  // One more than the TLB holds
  localparam logic [21:0] ROOT_PPN  = 22'h00100;
  localparam logic [31:0] SATP_SV32 = {1'b1, 9'h0, ROOT_PPN};
  localparam logic [1:0]  PRIV_USER = 2'd0;
  localparam logic [1:0]  PRIV_SUP  = 2'd1;
  localparam logic [1:0]  PRIV_MACH = 2'd3;

  // PTE flag bits
  localparam logic [7:0] F_V = 8'h01;
  localparam logic [7:0] F_R = 8'h02;
  localparam logic [7:0] F_W = 8'h04;
  localparam logic [7:0] F_X = 8'h08;
  localparam logic [7:0] F_U = 8'h10;

  logic        clk;
  logic        reset_n;
  logic        req;
  logic [31:0] vaddr;
  logic        is_store;
  logic        is_fetch;
  logic        ack;
  logic [33:0] paddr;
  logic        page_fault;
  logic        mem_req;
  logic [33:0] mem_addr;
  logic        mem_ack;
  logic [31:0] mem_rdata;
  logic [31:0] satp;
  logic [1:0]  priv;
  logic        mstatus_sum;
  logic        mstatus_mxr;
  logic        flush_all;
  logic        flush_page;
  logic [31:0] flush_vaddr;

  logic [31:0] pt_mem [logic [33:0]];  // Sparse page tables where a missing entry reads invalid
  logic [33:0] read_log [$];           // Addresses served since last clear
  logic [31:0] lfsr_state = 32'hcd00_1260;
  int          error_count  = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;

  tb_clock_gen u_clk (
    .clk     (clk),
    .reset_n (reset_n)
  );

  sv32_mmu DUT (
    .clk         (clk),
    .reset_n     (reset_n),
    .req         (req),
    .vaddr       (vaddr),
    .is_store    (is_store),
    .is_fetch    (is_fetch),
    .ack         (ack),
    .paddr       (paddr),
    .page_fault  (page_fault),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata),
    .satp        (satp),
    .priv        (priv),
    .mstatus_sum (mstatus_sum),
    .mstatus_mxr (mstatus_mxr),
    .flush_all   (flush_all),
    .flush_page  (flush_page),
    .flush_vaddr (flush_vaddr)
  );

  // ====================
  // Reference helpers
  // ====================
  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] lfsr_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // Second-level table per VPN[1] at a fixed PPN
  function automatic logic [21:0] table_ppn(logic [31:0] va);
    return 22'h200 + {12'h0, va[31:22]};
  endfunction

  function automatic logic [33:0] root_pte_addr(logic [31:0] va);
    return {ROOT_PPN, 12'h000} + {22'h0, va[31:22], 2'b00};  // VPN[1] * 4
  endfunction

  function automatic logic [33:0] leaf_pte_addr(logic [31:0] va);
    return {table_ppn(va), 12'h000} + {22'h0, va[21:12], 2'b00};  // VPN[0] * 4
  endfunction

  function automatic logic [33:0] pa_4k(logic [21:0] ppn, logic [31:0] va);
    return {ppn, va[11:0]};
  endfunction

  function automatic logic [33:0] pa_mega(logic [21:0] ppn, logic [31:0] va);
    return {ppn[21:10], va[21:0]};  // PPN[1] and 22 VA bits
  endfunction

  task automatic map_4k(input logic [31:0] va, input logic [21:0] ppn, input logic [7:0] fl);
    pt_mem[root_pte_addr(va)] = {table_ppn(va), 2'b00, F_V};  // Pointer
    pt_mem[leaf_pte_addr(va)] = {ppn, 2'b00, fl};
  endtask

  task automatic map_mega(input logic [31:0] va, input logic [21:0] ppn, input logic [7:0] fl);
    pt_mem[root_pte_addr(va)] = {ppn, 2'b00, fl};
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("%-14s ok", name);
    end else begin
      tests_failed++;
      $display("%-14s failed with %0d errors", name, error_count - errs_before);
    end
  endtask

  // ====================
  // Page-table memory
  // ====================
  initial begin : mem_model
    int delay;
    mem_ack   = 1'b0;
    mem_rdata = 32'h0;
    forever begin
      @(posedge clk);
      #1;
      if (mem_req && !mem_ack) begin
        delay = int'(lfsr_bits(2));  // 0 to 3 cycles
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        mem_rdata = pt_mem.exists(mem_addr) ? pt_mem[mem_addr] : 32'h0;
        read_log.push_back(mem_addr);
        mem_ack = 1'b1;
        while (mem_req) begin  // Hold until master lets go
          @(posedge clk);
          #1;
        end
        mem_ack = 1'b0;
      end
    end
  end

  // ====================
  // Request driver
  // ====================
  task automatic do_access(input logic [31:0] va, input logic st, input logic fe,
                           output logic [33:0] pa, output logic pf);
    @(posedge clk);
    #1;
    vaddr    = va;
    is_store = st;
    is_fetch = fe;
    req      = 1'b1;
    while (ack !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    pa  = paddr;
    pf  = page_fault;
    req = 1'b0;
    while (ack !== 1'b0) begin  // Four-phase close
      @(posedge clk);
      #1;
    end
  endtask

  // Negative exp_reads skips the read count
  task automatic check_access(input string what, input logic [31:0] va, input logic st,
                              input logic fe, input logic exp_pf, input logic [33:0] exp_pa,
                              input int exp_reads);
    logic [33:0] pa;
    logic        pf;
    read_log.delete();
    do_access(va, st, fe, pa, pf);
    if (pf !== exp_pf) begin
      report_error($sformatf("%s: page_fault %b, expected %b", what, pf, exp_pf));
    end
    if (!exp_pf && pa !== exp_pa) begin
      report_error($sformatf("%s: paddr %h, expected %h", what, pa, exp_pa));
    end
    if (exp_reads >= 0 && read_log.size() != exp_reads) begin
      report_error($sformatf("%s: %0d memory reads, expected %0d",
                             what, read_log.size(), exp_reads));
    end
  endtask

  task automatic pulse_flush(input logic all, input logic [31:0] va);
    @(posedge clk);
    #1;
    flush_all   = all;
    flush_page  = !all;
    flush_vaddr = va;
    @(posedge clk);
    #1;
    flush_all  = 1'b0;
    flush_page = 1'b0;
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic bare_mode_test();
    int errs0;
    errs0 = error_count;
    satp = 32'h0;  // MODE clear
    check_access("bare satp", 32'h8765_4321, 1'b0, 1'b0, 1'b0, {2'b00, 32'h8765_4321}, 0);
    satp = SATP_SV32;
    priv = PRIV_MACH;  // M-mode never translates
    check_access("bare m-mode", 32'h1234_5678, 1'b1, 1'b0, 1'b0, {2'b00, 32'h1234_5678}, 0);
    priv = PRIV_SUP;
    finish_test("bare_mode", errs0);
  endtask

  task automatic walk_and_hit_test();
    int          errs0;
    logic [31:0] va;
    errs0 = error_count;
    va = 32'h0040_3abc;  // VPN[1] 1 and VPN[0] 3
    map_4k(va, 22'h0_1234, F_V | F_R | F_W);
    check_access("4k walk", va, 1'b0, 1'b0, 1'b0, pa_4k(22'h0_1234, va), 2);
    if (read_log.size() == 2) begin
      if (read_log[0] !== root_pte_addr(va)) begin
        report_error($sformatf("4k walk: first read %h, expected %h",
                               read_log[0], root_pte_addr(va)));
      end
      if (read_log[1] !== leaf_pte_addr(va)) begin
        report_error($sformatf("4k walk: second read %h, expected %h",
                               read_log[1], leaf_pte_addr(va)));
      end
    end
    check_access("4k hit", va, 1'b0, 1'b0, 1'b0, pa_4k(22'h0_1234, va), 0);
    check_access("4k hit offset", va + 32'h10, 1'b1, 1'b0, 1'b0,
                 pa_4k(22'h0_1234, va + 32'h10), 0);
    finish_test("walk_then_hit", errs0);
  endtask

  task automatic megapage_test();
    int          errs0;
    logic [31:0] va;
    errs0 = error_count;
    va = 32'h0c12_3456;  // VPN[1] 0x30
    map_mega(va, {12'h5a3, 10'h0}, F_V | F_R | F_X);
    check_access("megapage walk", va, 1'b0, 1'b0, 1'b0, pa_mega({12'h5a3, 10'h0}, va), 1);
    if (read_log.size() == 1 && read_log[0] !== root_pte_addr(va)) begin
      report_error($sformatf("megapage: read %h, expected %h", read_log[0], root_pte_addr(va)));
    end
    check_access("megapage hit", va ^ 32'h0015_0000, 1'b0, 1'b1, 1'b0,
                 pa_mega({12'h5a3, 10'h0}, va ^ 32'h0015_0000), 0);
    finish_test("megapage", errs0);
  endtask

  task automatic permission_test();
    int          errs0;
    logic [31:0] va [1:8];
    errs0 = error_count;
    for (int n = 1; n <= 8; n++) begin
      va[n] = 32'h0080_0000 | (n << 12);  // VPN[1] 2 with one page per case
    end
    map_4k(va[1], 22'h1001, 8'h00);             // Invalid leaf
    map_4k(va[2], 22'h1002, F_V | F_W | F_X);   // Leaf by X, W without R
    map_4k(va[3], 22'h1003, F_V);               // Pointer at level 0
    map_4k(va[4], 22'h1004, F_V | F_R);
    map_4k(va[5], 22'h1005, F_V | F_R | F_U);
    map_4k(va[6], 22'h1006, F_V | F_R);         // Read-only
    map_4k(va[7], 22'h1007, F_V | F_R);
    map_4k(va[8], 22'h1008, F_V | F_X);         // Execute-only

    check_access("root invalid", 32'hffc0_0000, 1'b0, 1'b0, 1'b1, 34'h0, 1);
    check_access("leaf invalid", va[1], 1'b0, 1'b0, 1'b1, 34'h0, 2);
    check_access("w without r", va[2], 1'b1, 1'b0, 1'b1, 34'h0, 2);
    check_access("pointer at l0", va[3], 1'b0, 1'b0, 1'b1, 34'h0, 2);
    priv = PRIV_USER;
    check_access("user no u", va[4], 1'b0, 1'b0, 1'b1, 34'h0, 2);
    priv = PRIV_SUP;

    // SUM on walk then on hit
    check_access("u page no sum", va[5], 1'b0, 1'b0, 1'b1, 34'h0, 2);
    mstatus_sum = 1'b1;
    check_access("u page sum", va[5], 1'b0, 1'b0, 1'b0, pa_4k(22'h1005, va[5]), 2);
    mstatus_sum = 1'b0;
    check_access("u page hit no sum", va[5], 1'b0, 1'b0, 1'b1, 34'h0, 0);

    // Read-only page, walk then hit
    check_access("store ro walk", va[6], 1'b1, 1'b0, 1'b1, 34'h0, 2);
    check_access("load ro", va[6], 1'b0, 1'b0, 1'b0, pa_4k(22'h1006, va[6]), 2);
    check_access("store ro hit", va[6], 1'b1, 1'b0, 1'b1, 34'h0, 0);
    check_access("fetch no x hit", va[6], 1'b0, 1'b1, 1'b1, 34'h0, 0);
    check_access("fetch no x walk", va[7], 1'b0, 1'b1, 1'b1, 34'h0, 2);

    // MXR on walk then on hit
    check_access("x-only load", va[8], 1'b0, 1'b0, 1'b1, 34'h0, 2);
    mstatus_mxr = 1'b1;
    check_access("x-only load mxr", va[8], 1'b0, 1'b0, 1'b0, pa_4k(22'h1008, va[8]), 2);
    mstatus_mxr = 1'b0;
    check_access("x-only hit no mxr", va[8], 1'b0, 1'b0, 1'b1, 34'h0, 0);
    finish_test("permissions", errs0);
  endtask

  task automatic flush_test();
    int          errs0;
    logic [31:0] va_a;
    logic [31:0] va_b;
    errs0 = error_count;
    va_a = 32'h0100_5000;
    va_b = 32'h0100_6000;
    map_4k(va_a, 22'h0_0aaa, F_V | F_R);
    map_4k(va_b, 22'h0_0ccc, F_V | F_R);
    check_access("flush cache a", va_a, 1'b0, 1'b0, 1'b0, pa_4k(22'h0_0aaa, va_a), 2);
    map_4k(va_a, 22'h0_0bbb, F_V | F_R);  // Remap behind the TLB
    check_access("stale hit a", va_a, 1'b0, 1'b0, 1'b0, pa_4k(22'h0_0aaa, va_a), 0);
    pulse_flush(1'b0, va_b);
    check_access("other flushed", va_a, 1'b0, 1'b0, 1'b0, pa_4k(22'h0_0aaa, va_a), 0);
    pulse_flush(1'b0, va_a + 32'h123);
    check_access("page flushed", va_a, 1'b0, 1'b0, 1'b0, pa_4k(22'h0_0bbb, va_a), 2);

    check_access("flush cache b", va_b, 1'b0, 1'b0, 1'b0, pa_4k(22'h0_0ccc, va_b), 2);
    pulse_flush(1'b1, 32'h0);
    check_access("all flushed a", va_a, 1'b0, 1'b0, 1'b0, pa_4k(22'h0_0bbb, va_a), 2);
    check_access("all flushed b", va_b, 1'b0, 1'b0, 1'b0, pa_4k(22'h0_0ccc, va_b), 2);
    finish_test("flush", errs0);
  endtask

  task automatic round_robin_test();
    int          errs0;
    logic [31:0] pages [RR_PAGES];
    logic [31:0] lo;
    logic [31:0] off;
    logic [21:0] ppn;
    errs0 = error_count;
    pulse_flush(1'b1, 32'h0);
    for (int i = 0; i < RR_PAGES; i++) begin
      lo  = lfsr_bits(6);
      off = lfsr_bits(12);
      pages[i] = {10'd8, i[3:0], lo[5:0], off[11:0]};  // Index bits keep pages distinct
      ppn = 22'h3000 + {12'h0, pages[i][21:12]};
      map_4k(pages[i], ppn, F_V | F_R | F_W);
      check_access("rr fill", pages[i], 1'b0, 1'b0, 1'b0, pa_4k(ppn, pages[i]), 2);
    end
    // Oldest page evicted and its refill evicts the second
    ppn = 22'h3000 + {12'h0, pages[0][21:12]};
    check_access("rr evicted", pages[0], 1'b0, 1'b0, 1'b0, pa_4k(ppn, pages[0]), 2);
    for (int i = RR_PAGES - 1; i >= 2; i--) begin
      ppn = 22'h3000 + {12'h0, pages[i][21:12]};
      check_access("rr resident", pages[i], 1'b0, 1'b0, 1'b0, pa_4k(ppn, pages[i]), 0);
    end
    finish_test("round_robin", errs0);
  endtask

  // ====================
  // Sequence and watchdog
  // ====================
  initial begin : main
    req         = 1'b0;
    vaddr       = 32'h0;
    is_store    = 1'b0;
    is_fetch    = 1'b0;
    satp        = SATP_SV32;
    priv        = PRIV_SUP;
    mstatus_sum = 1'b0;
    mstatus_mxr = 1'b0;
    flush_all   = 1'b0;
    flush_page  = 1'b0;
    flush_vaddr = 32'h0;
    wait (reset_n === 1'b1);
    repeat (2) @(posedge clk);
    #1;

    bare_mode_test();
    walk_and_hit_test();
    megapage_test();
    permission_test();
    flush_test();
    round_robin_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (200 * NUM_TESTS) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", 200 * NUM_TESTS);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sv32_mmu.f */
+incdir+source
source/sv32_mmu_pkg.sv
source/mmu_ifs.sv
source/mmu_tlb.sv
source/mmu_perm_check.sv
source/mmu_page_walker.sv
source/mmu_xlate_ctrl.sv
source/sv32_mmu.sv
tb/tb_clock_gen.sv
tb/tb_sv32_mmu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the sv32_mmu testbench with Verilator, run it, scan the log

set -u
cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir

verilator --binary -j 0 -Wno-fatal -f sv32_mmu.f --top-module tb_sv32_mmu \
  -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/sim_tb" | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

echo "Simulation completed, log in $LOG"
exit 0
